// File: src.f
+incdir+include
hdl/csrPkg.sv
hdl/machineCsrs.sv
hdl/pmpCsrs.sv
hdl/csrReadMerge.sv
hdl/csrMachineTop.sv
tests/clockGen.sv
tests/csrMachineTb.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := csrMachineTb
FILELIST  := src.f
OBJDIR    := obj_dir
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: tests/csrMachineTb.sv
`timescale 1ns/10ps

module csrMachineTb;

  // One table row holds stimulus and what the read port must show in that cycle
  typedef struct packed {
    csrPkg::csrReqT   req;
    csrPkg::trapInfoT trap;
    logic             randData;
    logic             fromModel;
    logic [31:0]      expData;
    logic             expIllegal;
  } stepT;

  logic                clk;
  logic                rstN;
  csrPkg::csrReqT      req;
  csrPkg::trapInfoT    trap;
  logic [31:0]         readData;
  logic                illegalAccess;
  logic [31:0]         mtvec;
  logic [31:0]         mepc;
  logic [15:0]         medeleg;
  logic [11:0]         mideleg;
  csrPkg::pmpCfgArrayT pmpCfg;
  logic [15:0][31:0]   pmpAddr;

  stepT        steps[$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycleLimit = 0;
  logic [31:0] rngState = 32'd15723;

  // Reference model state
  logic [31:0] refMtvec = '0;
  logic [31:0] refMepc = '0;
  logic [31:0] refMcause = '0;
  logic [31:0] refMtval = '0;
  logic [31:0] refMscratch = '0;
  logic [15:0] refMedeleg = '0;
  logic [11:0] refMideleg = '0;
  logic [7:0]  refPmpCfg [16] = '{default: '0};
  logic [31:0] refPmpAddr [16] = '{default: '0};

  clockGen uClock (
    .clk  (clk),
    .rstN (rstN)
  );

  csrMachineTop dut (
    .clk           (clk),
    .rstN          (rstN),
    .req           (req),
    .trap          (trap),
    .readData      (readData),
    .illegalAccess (illegalAccess),
    .mtvec         (mtvec),
    .mepc          (mepc),
    .medeleg       (medeleg),
    .mideleg       (mideleg),
    .pmpCfg        (pmpCfg),
    .pmpAddr       (pmpAddr)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////
  // Table rows
  //////////////////////////////

  task automatic readRow(input logic [11:0] addr, input logic [31:0] expData,
                         input logic fromModel, input logic expIllegal);
    stepT s;
    s = '0;
    s.req.addr = addr;
    s.fromModel = fromModel;
    s.expData = expData;
    s.expIllegal = expIllegal;
    steps.push_back(s);
  endtask

  // Read port shows the old value during a write
  task automatic writeRow(input logic [11:0] addr, input logic [31:0] data,
                          input logic randData, input logic expIllegal);
    stepT s;
    s = '0;
    s.req.write = 1'b1;
    s.req.addr = addr;
    s.req.wdata = data;
    s.randData = randData;
    s.fromModel = 1'b1;
    s.expIllegal = expIllegal;
    steps.push_back(s);
  endtask

  task automatic trapRow(input logic [31:0] epc, input logic [4:0] cause, input logic [31:0] tval,
                         input logic [11:0] addr, input logic [31:0] data);
    stepT s;
    s = '0;
    s.trap.valid = 1'b1;
    s.trap.epc = epc;
    s.trap.cause = cause;
    s.trap.tval = tval;
    s.req.write = 1'b1;
    s.req.addr = addr;
    s.req.wdata = data;
    s.fromModel = 1'b1;
    steps.push_back(s);
  endtask

  task automatic buildTable();
    // Reset values
    readRow(csrPkg::MSCRATCH, 32'h0, 1'b0, 1'b0);
    readRow(csrPkg::MTVEC, 32'h0, 1'b0, 1'b0);
    readRow(csrPkg::MEPC, 32'h0, 1'b0, 1'b0);
    readRow(csrPkg::PMPCFG0, 32'h0, 1'b0, 1'b0);
    // Scratch and vector
    writeRow(csrPkg::MSCRATCH, 32'h0, 1'b1, 1'b0);
    readRow(csrPkg::MSCRATCH, 32'h0, 1'b1, 1'b0);
    writeRow(csrPkg::MTVEC, 32'h8000_0007, 1'b0, 1'b0);
    readRow(csrPkg::MTVEC, 32'h8000_0005, 1'b0, 1'b0);
    writeRow(csrPkg::MTVEC, 32'h0, 1'b1, 1'b0);
    readRow(csrPkg::MTVEC, 32'h0, 1'b1, 1'b0);
    // Trap against a same-cycle core write
    trapRow(32'h0000_1234, 5'h17, 32'hDEAD_BEEF, csrPkg::MEPC, 32'h5555_AAAA);
    readRow(csrPkg::MEPC, 32'h0000_1234, 1'b0, 1'b0);
    readRow(csrPkg::MCAUSE, 32'h8000_0007, 1'b0, 1'b0);
    readRow(csrPkg::MTVAL, 32'hDEAD_BEEF, 1'b0, 1'b0);
    trapRow(32'h0000_2000, 5'h02, 32'h0, csrPkg::MCAUSE, 32'hFFFF_FFFF);
    readRow(csrPkg::MCAUSE, 32'h0000_0002, 1'b0, 1'b0);
    // Delegation masks
    writeRow(csrPkg::MEDELEG, 32'hFFFF_FFFF, 1'b0, 1'b0);
    readRow(csrPkg::MEDELEG, 32'h0000_B3FF, 1'b0, 1'b0);
    writeRow(csrPkg::MIDELEG, 32'hFFFF_FFFF, 1'b0, 1'b0);
    readRow(csrPkg::MIDELEG, 32'h0000_0222, 1'b0, 1'b0);
    // PMP packing and locks
    writeRow(csrPkg::PMPCFG0, 32'h0F0E_0D0C, 1'b0, 1'b0);
    readRow(csrPkg::PMPCFG0, 32'h0F0E_0D0C, 1'b0, 1'b0);
    writeRow(csrPkg::PMPADDR0, 32'h1234_5678, 1'b0, 1'b0);
    readRow(csrPkg::PMPADDR0, 32'h1234_5678, 1'b0, 1'b0);
    writeRow(csrPkg::PMPCFG0, 32'h0000_8801, 1'b0, 1'b0);
    writeRow(csrPkg::PMPCFG0, 32'h9000_0000, 1'b0, 1'b0);
    readRow(csrPkg::PMPCFG0, 32'h9000_8800, 1'b0, 1'b0);
    writeRow(csrPkg::PMPADDR0, 32'h0, 1'b1, 1'b0);
    readRow(csrPkg::PMPADDR0, 32'h1234_5678, 1'b0, 1'b0);
    writeRow(csrPkg::PMPADDR0 + 12'd2, 32'h0, 1'b1, 1'b0);
    readRow(csrPkg::PMPADDR0 + 12'd2, 32'h0, 1'b1, 1'b0);
    writeRow(csrPkg::PMPADDR0 + 12'd3, 32'h0, 1'b1, 1'b0);
    readRow(csrPkg::PMPADDR0 + 12'd3, 32'h0, 1'b0, 1'b0);
    // Identity and unmapped addresses
    readRow(csrPkg::MISA, 32'h4014_1100, 1'b0, 1'b0);
    readRow(csrPkg::MIMPID, 32'h0000_0100, 1'b0, 1'b0);
    readRow(csrPkg::MHARTID, 32'h0, 1'b0, 1'b0);
    writeRow(csrPkg::MVENDORID, 32'h0, 1'b1, 1'b1);
    readRow(csrPkg::MVENDORID, 32'h0, 1'b0, 1'b0);
    readRow(12'h300, 32'h0, 1'b0, 1'b1);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] modelRead(input logic [11:0] addr);
    logic [31:0] value;
    int n;
    value = '0;
    case (addr)
      csrPkg::MISA:     value = 32'h4014_1100;
      csrPkg::MIMPID:   value = 32'h0000_0100;
      csrPkg::MTVEC:    value = refMtvec;
      csrPkg::MEDELEG:  value = {16'h0, refMedeleg};
      csrPkg::MIDELEG:  value = {20'h0, refMideleg};
      csrPkg::MSCRATCH: value = refMscratch;
      csrPkg::MEPC:     value = refMepc;
      csrPkg::MCAUSE:   value = refMcause;
      csrPkg::MTVAL:    value = refMtval;
      default: begin
        n = int'(addr - csrPkg::PMPCFG0);
        if (n >= 0 && n < 4) begin
          for (int b = 0; b < 4; b++) value[8*b +: 8] = refPmpCfg[4*n + b];
        end
        n = int'(addr - csrPkg::PMPADDR0);
        if (n >= 0 && n < 16) value = refPmpAddr[n];
      end
    endcase
    return value;
  endfunction

  task automatic modelUpdate(input stepT s);
    int n;
    logic locked;
    if (s.trap.valid) begin
      refMepc = s.trap.epc;
      refMcause = {s.trap.cause[4], 27'h0, s.trap.cause[3:0]};
      refMtval = s.trap.tval;
    end
    if (s.req.write) begin
      case (s.req.addr)
        csrPkg::MTVEC:    refMtvec = s.req.wdata & 32'hFFFF_FFFD;
        csrPkg::MEDELEG:  refMedeleg = s.req.wdata[15:0] & 16'hB3FF;
        csrPkg::MIDELEG:  refMideleg = s.req.wdata[11:0] & 12'h222;
        csrPkg::MSCRATCH: refMscratch = s.req.wdata;
        csrPkg::MEPC:     if (!s.trap.valid) refMepc = s.req.wdata;
        csrPkg::MCAUSE: begin
          if (!s.trap.valid) refMcause = {s.req.wdata[31], 27'h0, s.req.wdata[3:0]};
        end
        csrPkg::MTVAL:    if (!s.trap.valid) refMtval = s.req.wdata;
        default: begin
          n = int'(s.req.addr - csrPkg::PMPCFG0);
          if (n >= 0 && n < 4) begin
            for (int b = 0; b < 4; b++) begin
              if (!refPmpCfg[4*n + b][7]) refPmpCfg[4*n + b] = s.req.wdata[8*b +: 8];
            end
          end
          n = int'(s.req.addr - csrPkg::PMPADDR0);
          if (n >= 0 && n < 16) begin
            // Own lock or a locked TOR entry just above
            locked = refPmpCfg[n][7];
            if (n < 15) begin
              locked = locked | (refPmpCfg[n+1][7] & (refPmpCfg[n+1][4:3] == 2'b01));
            end
            if (!locked) refPmpAddr[n] = s.req.wdata;
          end
        end
      endcase
    end
  endtask

  //////////////////////////////
  // Checks
  //////////////////////////////

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error at time %0t: %s is 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic checkOutputs();
    checkEq("mtvec", mtvec, refMtvec);
    checkEq("mepc", mepc, refMepc);
    checkEq("medeleg", 32'(medeleg), {16'h0, refMedeleg});
    checkEq("mideleg", 32'(mideleg), {20'h0, refMideleg});
    for (int i = 0; i < 16; i++) begin
      checkEq($sformatf("pmpCfg[%0d]", i), 32'(pmpCfg[i]), 32'(refPmpCfg[i]));
      checkEq($sformatf("pmpAddr[%0d]", i), pmpAddr[i], refPmpAddr[i]);
    end
  endtask

  // Guard against a stalled run
  always @(posedge clk) begin
    cycles++;
    if (cycleLimit > 0 && cycles > cycleLimit) begin
      $display("Timeout: the run went past its limit of %0d cycles", cycleLimit);
      $display("Finished with errors");
      $finish;
    end
  end

  initial begin
    stepT s;
    logic [31:0] expRead;
    req = '0;
    trap = '0;
    buildTable();
    cycleLimit = 2 * steps.size() + 8 + 20;
    wait (rstN === 1'b1);
    for (int k = 0; k < steps.size(); k++) begin
      s = steps[k];
      if (s.randData) begin
        rngState = xorshift(rngState);
        s.req.wdata = rngState;
      end
      @(posedge clk);
      req <= s.req;
      trap <= s.trap;
      // Reads are combinational so sample mid-cycle
      @(negedge clk);
      expRead = s.fromModel ? modelRead(s.req.addr) : s.expData;
      checkEq("readData", readData, expRead);
      checkEq("illegalAccess", 32'(illegalAccess), 32'(s.expIllegal));
      checkOutputs();
      modelUpdate(s);
    end
    @(posedge clk);
    req <= '0;
    trap <= '0;
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tests/clockGen.sv
`timescale 1ns/10ps

module clockGen #(
  parameter int halfPeriod  = 10,
  parameter int resetCycles = 8
) (
  output logic clk,
  output logic rstN
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  // Reset released on a rising edge after the hold time
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// File: hdl/csrMachineTop.sv
`timescale 1ns/10ps
`include "csr_params.svh"

module csrMachineTop (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  csrPkg::csrReqT                                   req,
  input  csrPkg::trapInfoT                                 trap,
  output logic [`CSR_XLEN-1:0]                             readData,
  output logic                                             illegalAccess,
  output logic [`CSR_XLEN-1:0]                             mtvec,
  output logic [`CSR_XLEN-1:0]                             mepc,
  output logic [15:0]                                      medeleg,
  output logic [11:0]                                      mideleg,
  output csrPkg::pmpCfgArrayT                              pmpCfg,
  output logic [`CSR_PMP_ENTRIES-1:0][`CSR_PA_BITS-3:0]    pmpAddr
);

  csrPkg::csrRespT machineResp;
  csrPkg::csrRespT pmpResp;

  // Trap and configuration registers
  machineCsrs uMachine (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .trap    (trap),
    .resp    (machineResp),
    .mtvec   (mtvec),
    .mepc    (mepc),
    .medeleg (medeleg),
    .mideleg (mideleg)
  );

  // Physical memory protection registers
  pmpCsrs uPmp (
    .clk     (clk),
    .rstN    (rstN),
    .req     (req),
    .resp    (pmpResp),
    .pmpCfg  (pmpCfg),
    .pmpAddr (pmpAddr)
  );

  csrReadMerge uMerge (
    .machineResp   (machineResp),
    .pmpResp       (pmpResp),
    .write         (req.write),
    .readData      (readData),
    .illegalAccess (illegalAccess)
  );

endmodule

// File: hdl/csrReadMerge.sv
`timescale 1ns/10ps
`include "csr_params.svh"

module csrReadMerge (
  input  csrPkg::csrRespT       machineResp,
  input  csrPkg::csrRespT       pmpResp,
  input  logic                  write,
  output logic [`CSR_XLEN-1:0]  readData,
  output logic                  illegalAccess
);

  logic anyHit;
  logic hitReadOnly;

  //////////////////////////////
  // Select and flag
  //////////////////////////////

  assign anyHit = machineResp.hit | pmpResp.hit;

  // Only a part that claims the address can mark it read-only
  assign hitReadOnly = (machineResp.hit & machineResp.readOnly) |
                       (pmpResp.hit & pmpResp.readOnly);

  always_comb begin
    if (machineResp.hit) begin
      readData = machineResp.rdata;
    end else if (pmpResp.hit) begin
      readData = pmpResp.rdata;
    end else begin
      // Unknown address reads as zero
      readData = '0;
    end
  end

  // Unmapped address, or a write to a hardwired register
  assign illegalAccess = ~anyHit | (write & hitReadOnly);

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Address maps of the two parts are disjoint
  always_comb begin
    noDoubleHit: assert final (!(machineResp.hit & pmpResp.hit));
  end

endmodule

// File: hdl/pmpCsrs.sv
`timescale 1ns/10ps
`include "csr_params.svh"

module pmpCsrs (
  input  logic                                             clk,
  input  logic                                             rstN,
  input  csrPkg::csrReqT                                   req,
  output csrPkg::csrRespT                                  resp,
  output csrPkg::pmpCfgArrayT                              pmpCfg,
  output logic [`CSR_PMP_ENTRIES-1:0][`CSR_PA_BITS-3:0]    pmpAddr
);

  localparam int entries    = `CSR_PMP_ENTRIES;
  localparam int cfgRegs    = entries / 4;
  localparam int idxBits    = $clog2(entries);
  localparam int cfgIdxBits = $clog2(cfgRegs);
  localparam int addrBits   = `CSR_PA_BITS - 2;

  logic [entries-1:0] cfgLocked;
  logic [entries-1:0] addrLocked;
  logic [entries-1:0] writeCfg;
  logic [entries-1:0] writeAddr;
  logic [11:0]        cfgOffset;
  logic [11:0]        addrOffset;

  //////////////////////////////
  // Lock rules and write decode
  //////////////////////////////

  for (genvar i = 0; i < entries; i++) begin : gEntry
    assign cfgLocked[i] = pmpCfg[i][7];

    // A locked TOR entry also protects the address below it
    if (i == entries - 1) begin : gLast
      assign addrLocked[i] = pmpCfg[i][7];
    end else begin : gInner
      assign addrLocked[i] = pmpCfg[i][7] |
                             (pmpCfg[i+1][7] & (pmpCfg[i+1][4:3] == 2'b01));
    end

    assign writeCfg[i]  = req.write & (req.addr == csrPkg::PMPCFG0 + 12'(i / 4)) &
                          ~cfgLocked[i];
    assign writeAddr[i] = req.write & (req.addr == csrPkg::PMPADDR0 + 12'(i)) &
                          ~addrLocked[i];
  end

  //////////////////////////////
  // Registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      pmpCfg  <= '0;
      pmpAddr <= '0;
    end else begin
      for (int i = 0; i < entries; i++) begin
        // Byte lane within the pmpcfg word
        if (writeCfg[i]) pmpCfg[i] <= req.wdata[(i % 4) * 8 +: 8];
        if (writeAddr[i]) pmpAddr[i] <= req.wdata[addrBits-1:0];
      end
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  // Addresses below the base wrap to large offsets and miss
  assign cfgOffset  = req.addr - csrPkg::PMPCFG0;
  assign addrOffset = req.addr - csrPkg::PMPADDR0;

  always_comb begin
    resp = '0;
    if (addrOffset < 12'(entries)) begin
      resp.hit   = 1'b1;
      resp.rdata = pmpAddr[addrOffset[idxBits-1:0]];
    end else if (cfgOffset < 12'(cfgRegs)) begin
      resp.hit   = 1'b1;
      // Entry 4n lands in the low byte
      resp.rdata = pmpCfg[{cfgOffset[cfgIdxBits-1:0], 2'b00} +: 4];
    end
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // One core access per cycle can touch only one pmpaddr
  oneAddrWrite: assert property (
    @(posedge clk) disable iff (!rstN)
    $onehot0(writeAddr)
  );

endmodule

// File: hdl/machineCsrs.sv
`timescale 1ns/10ps
`include "csr_params.svh"

module machineCsrs (
  input  logic                  clk,
  input  logic                  rstN,
  input  csrPkg::csrReqT        req,
  input  csrPkg::trapInfoT      trap,
  output csrPkg::csrRespT       resp,
  output logic [`CSR_XLEN-1:0]  mtvec,
  output logic [`CSR_XLEN-1:0]  mepc,
  output logic [15:0]           medeleg,
  output logic [11:0]           mideleg
);

  localparam logic [`CSR_XLEN-1:0] misaValue = `CSR_MISA_MXL | `CSR_MISA_EXT;

  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mtval;
  logic [31:0]          mcountinhibit;
  logic [31:0]          mcounteren;

  logic wrMtvec;
  logic wrMedeleg;
  logic wrMideleg;
  logic wrMscratch;
  logic wrMepc;
  logic wrMcause;
  logic wrMtval;
  logic wrMcountinhibit;
  logic wrMcounteren;

  //////////////////////////////
  // Write decode
  //////////////////////////////

  assign wrMtvec         = req.write & (req.addr == csrPkg::MTVEC);
  assign wrMedeleg       = req.write & (req.addr == csrPkg::MEDELEG);
  assign wrMideleg       = req.write & (req.addr == csrPkg::MIDELEG);
  assign wrMscratch      = req.write & (req.addr == csrPkg::MSCRATCH);
  assign wrMepc          = req.write & (req.addr == csrPkg::MEPC);
  assign wrMcause        = req.write & (req.addr == csrPkg::MCAUSE);
  assign wrMtval         = req.write & (req.addr == csrPkg::MTVAL);
  assign wrMcountinhibit = req.write & (req.addr == csrPkg::MCOUNTINHIBIT);
  assign wrMcounteren    = req.write & (req.addr == csrPkg::MCOUNTEREN);

  //////////////////////////////
  // Registers
  //////////////////////////////

  // Configuration and scratch
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtvec         <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      mscratch      <= '0;
      mcountinhibit <= '0;
      mcounteren    <= '0;
    end else begin
      // Bit 1 of mtvec is reserved in the mode field
      if (wrMtvec)         mtvec         <= {req.wdata[`CSR_XLEN-1:2], 1'b0, req.wdata[0]};
      if (wrMedeleg)       medeleg       <= req.wdata[15:0] & `CSR_MEDELEG_MASK;
      if (wrMideleg)       mideleg       <= req.wdata[11:0] & `CSR_MIDELEG_MASK;
      if (wrMscratch)      mscratch      <= req.wdata;
      if (wrMcountinhibit) mcountinhibit <= req.wdata[31:0];
      if (wrMcounteren)    mcounteren    <= req.wdata[31:0];
    end
  end

  // Trap state, a trap pulse wins over a core write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mepc   <= '0;
      mcause <= '0;
      mtval  <= '0;
    end else if (trap.valid) begin
      mepc   <= trap.epc;
      mcause <= {trap.cause[4], {(`CSR_XLEN-5){1'b0}}, trap.cause[3:0]};
      mtval  <= trap.tval;
    end else begin
      if (wrMepc)   mepc   <= req.wdata;
      // Same layout as a trap: interrupt flag on top, code at the bottom
      if (wrMcause) mcause <= {req.wdata[`CSR_XLEN-1], {(`CSR_XLEN-5){1'b0}}, req.wdata[3:0]};
      if (wrMtval)  mtval  <= req.wdata;
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    resp = '0;
    resp.hit = 1'b1;
    case (req.addr)
      csrPkg::MISA: begin
        resp.readOnly = 1'b1;
        resp.rdata    = misaValue;
      end
      csrPkg::MIMPID: begin
        resp.readOnly = 1'b1;
        resp.rdata    = `CSR_MIMPID;
      end
      // Identity values hardwired to zero
      csrPkg::MVENDORID, csrPkg::MARCHID, csrPkg::MHARTID, csrPkg::MCONFIGPTR:
        resp.readOnly = 1'b1;
      csrPkg::MTVEC:         resp.rdata = mtvec;
      csrPkg::MEDELEG:       resp.rdata = {{(`CSR_XLEN-16){1'b0}}, medeleg};
      csrPkg::MIDELEG:       resp.rdata = {{(`CSR_XLEN-12){1'b0}}, mideleg};
      csrPkg::MSCRATCH:      resp.rdata = mscratch;
      csrPkg::MEPC:          resp.rdata = mepc;
      csrPkg::MCAUSE:        resp.rdata = mcause;
      csrPkg::MTVAL:         resp.rdata = mtval;
      csrPkg::MCOUNTINHIBIT: resp.rdata = mcountinhibit;
      csrPkg::MCOUNTEREN:    resp.rdata = mcounteren;
      default:               resp.hit   = 1'b0;
    endcase
  end

  //////////////////////////////
  // Checks
  //////////////////////////////

  // Whichever source loads mepc, the stored value is known
  mepcKnown: assert property (
    @(posedge clk) disable iff (!rstN)
    (trap.valid | wrMepc) |=> !$isunknown(mepc)
  );

  // Identity registers are part of this block's address map
  readOnlyHit: assert property (
    @(posedge clk) disable iff (!rstN)
    resp.readOnly |-> resp.hit
  );

endmodule

// File: hdl/csrPkg.sv
`include "csr_params.svh"

package csrPkg;

  //////////////////////////////
  // CSR addresses
  //////////////////////////////

  // Hardwired identity registers
  localparam logic [11:0] MVENDORID     = 12'hF11;
  localparam logic [11:0] MARCHID       = 12'hF12;
  localparam logic [11:0] MIMPID        = 12'hF13;
  localparam logic [11:0] MHARTID       = 12'hF14;
  localparam logic [11:0] MCONFIGPTR    = 12'hF15;

  // Trap setup
  localparam logic [11:0] MISA          = 12'h301;
  localparam logic [11:0] MEDELEG       = 12'h302;
  localparam logic [11:0] MIDELEG       = 12'h303;
  localparam logic [11:0] MTVEC         = 12'h305;
  localparam logic [11:0] MCOUNTEREN    = 12'h306;
  localparam logic [11:0] MCOUNTINHIBIT = 12'h320;

  // Trap handling
  localparam logic [11:0] MSCRATCH      = 12'h340;
  localparam logic [11:0] MEPC          = 12'h341;
  localparam logic [11:0] MCAUSE        = 12'h342;
  localparam logic [11:0] MTVAL         = 12'h343;

  // First of each PMP block, the rest follow at consecutive addresses
  localparam logic [11:0] PMPCFG0       = 12'h3A0;
  localparam logic [11:0] PMPADDR0      = 12'h3B0;

  //////////////////////////////
  // Interface structs
  //////////////////////////////

  // Core-side CSR access
  typedef struct packed {
    logic                 write;
    logic [11:0]          addr;
    logic [`CSR_XLEN-1:0] wdata;
  } csrReqT;

  // Trap event from the pipeline
  // cause[4] flags an interrupt, cause[3:0] is the code
  typedef struct packed {
    logic                 valid;
    logic [`CSR_XLEN-1:0] epc;
    logic [4:0]           cause;
    logic [`CSR_XLEN-1:0] tval;
  } trapInfoT;

  // One register block's answer for the current address
  typedef struct packed {
    logic                 hit;
    logic                 readOnly;
    logic [`CSR_XLEN-1:0] rdata;
  } csrRespT;

  // All PMP configuration bytes, entry 0 in the low byte
  typedef logic [`CSR_PMP_ENTRIES-1:0][7:0] pmpCfgArrayT;

endpackage

// File: include/csr_params.svh
`ifndef CSR_PARAMS_SVH
`define CSR_PARAMS_SVH

// Datapath width, RV32 only
`define CSR_XLEN 32

// PMP sizing
// Four configuration bytes share one pmpcfg register
`define CSR_PMP_ENTRIES 16
// pmpaddr holds physical address bits 33:2
`define CSR_PA_BITS 34

// Writable bits of the delegation registers
`define CSR_MEDELEG_MASK 16'hB3FF
`define CSR_MIDELEG_MASK 12'h222

// misa field values
// MXL = 1 for RV32
`define CSR_MISA_MXL 32'h4000_0000
// Extensions I, M, S and U
`define CSR_MISA_EXT 32'h0014_1100

// Implementation id, pipelined core
`define CSR_MIMPID 32'h0000_0100

`endif
